//--- if_cfg.svh
// Width, depth and limit macros shared by the fetch stage
`ifndef IF_CFG_SVH
`define IF_CFG_SVH

//////////////////////////////////////////////////
// Datapath widths fixed by the ISA
//////////////////////////////////////////////////

// Address and instruction word width
`define IF_XLEN 32
// Upper bits of mtvec kept as the trap base
`define IF_MTVEC_W 25
// Interrupt index width used for vectoring
`define IF_IRQ_ID_W 5
// Vector slot reserved for NMI
`define IF_NMI_INDEX 15

//////////////////////////////////////////////////
// Prefetch sizing
//////////////////////////////////////////////////

// Words held between the bus and IF/ID
`define IF_BUF_DEPTH 2
// In-flight plus buffered fetches allowed
`define IF_MAX_OUTSTANDING 2

`endif

//--- if_ctrl_pkg.sv
// Controller-side types: PC source enum, command struct and target address struct
`include "if_cfg.svh"

package if_ctrl_pkg;

  // Source of the next fetch address
  typedef enum logic [3:0] {
    PC_BOOT     = 4'd0,
    PC_JUMP     = 4'd1,
    PC_BRANCH   = 4'd2,
    PC_MRET     = 4'd3,
    PC_DRET     = 4'd4,
    PC_TRAP_EXC = 4'd5,
    PC_TRAP_IRQ = 4'd6,
    PC_TRAP_NMI = 4'd7,
    PC_TRAP_DBD = 4'd8
  } pc_mux_e;

  // Command from the controller FSM to IF
  typedef struct packed {
    logic                      pc_set;        // Redirect fetch this cycle
    pc_mux_e                   pc_mux;
    logic                      kill_if;       // Drop whatever IF holds
    logic                      halt_if;       // Freeze IF, no new loads
    logic [`IF_IRQ_ID_W-1:0]   mtvec_pc_mux;  // Interrupt index for vectoring
  } if_ctrl_t;

  // Candidate redirect addresses
  typedef struct packed {
    logic [`IF_XLEN-1:0]     boot_addr;
    logic [`IF_XLEN-1:0]     jump_target;    // From ID
    logic [`IF_XLEN-1:0]     branch_target;  // From EX
    logic [`IF_XLEN-1:0]     mepc;
    logic [`IF_XLEN-1:0]     dpc;
    logic [`IF_XLEN-1:0]     dm_halt_addr;
    logic [`IF_MTVEC_W-1:0]  mtvec_addr;     // Trap base, upper bits only
  } pc_targets_t;

endpackage

//--- if_data_pkg.sv
// Datapath types: instruction bus structs, instruction word union, buffer entry and IF/ID
`include "if_cfg.svh"

package if_data_pkg;

  //////////////////////////////////////////////////
  // Instruction bus
  //////////////////////////////////////////////////

  // Address phase, held until gnt
  typedef struct packed {
    logic                 req;
    logic [`IF_XLEN-1:0]  addr;
  } instr_req_t;

  // Grant and in-order response phase
  typedef struct packed {
    logic                 gnt;
    logic                 rvalid;
    logic [`IF_XLEN-1:0]  rdata;
    logic                 err;     // Bus error on this fetch
  } instr_rsp_t;

  //////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////

  // Two 16-bit parcels, low parcel first in memory
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } instr_parcels_t;

  // Same fetched word, seen whole or as parcels
  typedef union packed {
    logic [`IF_XLEN-1:0] word;
    instr_parcels_t      parcel;  // lo[1:0] != 2'b11 marks RVC
  } instr_word_u;

  //////////////////////////////////////////////////
  // Stage storage
  //////////////////////////////////////////////////

  // One fetched word waiting in the buffer
  typedef struct packed {
    logic [`IF_XLEN-1:0]  pc;
    instr_word_u          instr;
    logic                 err;
  } fetch_entry_t;

  // IF/ID pipeline register as seen by ID
  typedef struct packed {
    logic                 instr_valid;
    logic [`IF_XLEN-1:0]  pc;
    logic [`IF_XLEN-1:0]  instr;
    logic                 bus_err;
    logic                 is_compressed;
    logic [15:0]          compressed_instr;  // Last RVC parcel seen
  } if_id_t;

endpackage

//--- pc_select.sv
// Next-PC multiplexer with mtvec-init pulse on boot
`timescale 1ns/1ps
`include "if_cfg.svh"

module pc_select import if_ctrl_pkg::*; (
  input  if_ctrl_t             ctrl_i,
  input  pc_targets_t          targets_i,
  output logic [`IF_XLEN-1:0]  branch_addr_o,
  output logic                 csr_mtvec_init_o
);

  // NMI slot sized to the interrupt index field
  localparam logic [`IF_IRQ_ID_W-1:0] NMI_IDX = `IF_IRQ_ID_W'(`IF_NMI_INDEX);

  // Low zeros below the trap base, index field plus word offset
  localparam int unsigned TRAP_LSB_W = `IF_IRQ_ID_W + 2;

  always_comb begin
    // Boot address is the fallback
    branch_addr_o = {targets_i.boot_addr[`IF_XLEN-1:2], 2'b00};
    case (ctrl_i.pc_mux)
      PC_BOOT:     branch_addr_o = {targets_i.boot_addr[`IF_XLEN-1:2], 2'b00};
      PC_JUMP:     branch_addr_o = targets_i.jump_target;
      PC_BRANCH:   branch_addr_o = targets_i.branch_target;
      // Return from trap
      PC_MRET:     branch_addr_o = targets_i.mepc;
      // Return from debug mode
      PC_DRET:     branch_addr_o = targets_i.dpc;
      // Exceptions all share the base
      PC_TRAP_EXC: branch_addr_o = {targets_i.mtvec_addr, {TRAP_LSB_W{1'b0}}};
      // Vectored: base + index*4
      PC_TRAP_IRQ: branch_addr_o = {targets_i.mtvec_addr, ctrl_i.mtvec_pc_mux, 2'b00};
      PC_TRAP_NMI: branch_addr_o = {targets_i.mtvec_addr, NMI_IDX, 2'b00};
      // Debug halt entry
      PC_TRAP_DBD: branch_addr_o = {targets_i.dm_halt_addr[`IF_XLEN-1:2], 2'b00};
      default:     ;
    endcase
  end

  // Lets the CSR file load its mtvec reset value
  assign csr_mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BOOT);

endmodule

//--- fetch_fsm.sv
// Prefetch FSM owning the fetch address and the instruction bus request
`timescale 1ns/1ps
`include "if_cfg.svh"

module fetch_fsm import if_ctrl_pkg::*, if_data_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  if_ctrl_t             ctrl_i,
  input  logic [`IF_XLEN-1:0]  branch_addr_i,
  input  logic                 slot_free_i,
  input  logic                 bus_gnt_i,
  output instr_req_t           bus_req_o,
  output logic                 issue_o,
  output logic                 flush_o
);

  // IDLE      nothing to fetch until a redirect
  // REQUEST   req is out and waits for gnt
  // WAIT_SLOT stream active, req only with a free slot
  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_SLOT
  } state_e;

  state_e              state_q;
  state_e              state_d;
  logic [`IF_XLEN-1:0] addr_q;
  logic                req;

  //////////////////////////////////////////////////
  // Request generation
  //////////////////////////////////////////////////

  always_comb begin
    req = 1'b0;
    case (state_q)
      // Once raised, req stays up until granted
      REQUEST:   req = 1'b1;
      WAIT_SLOT: req = slot_free_i && !ctrl_i.halt_if && !ctrl_i.kill_if;
      default:   req = 1'b0;
    endcase
  end

  assign issue_o   = req && bus_gnt_i;
  assign flush_o   = ctrl_i.pc_set || ctrl_i.kill_if;
  assign bus_req_o = '{req: req, addr: addr_q};

  //////////////////////////////////////////////////
  // State and address
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    if (ctrl_i.pc_set) begin
      state_d = WAIT_SLOT;
    end else if (ctrl_i.kill_if) begin
      // Kill without redirect stops the stream
      state_d = IDLE;
    end else if (req && !bus_gnt_i) begin
      state_d = REQUEST;
    end else if (issue_o) begin
      state_d = WAIT_SLOT;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      // Redirect wins over a grant in the same cycle
      if (ctrl_i.pc_set) begin
        addr_q <= {branch_addr_i[`IF_XLEN-1:2], 2'b00};
      end else if (issue_o) begin
        addr_q <= addr_q + `IF_XLEN'd4;
      end
    end
  end

endmodule

//--- txn_counter.sv
// Outstanding fetch counter with discard tracking after a flush
`timescale 1ns/1ps
`include "if_cfg.svh"

module txn_counter (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                issue_i,
  input  logic                                rvalid_i,
  input  logic                                flush_i,
  input  logic [$clog2(`IF_BUF_DEPTH+1)-1:0]  buf_count_i,
  output logic                                slot_free_o,
  output logic                                accept_o,
  output logic                                busy_o
);

  // Room for old and new streams on the bus at once
  localparam int unsigned CNT_W = $clog2(`IF_MAX_OUTSTANDING * 2) + 1;

  logic [CNT_W-1:0] inflight_q;
  logic [CNT_W-1:0] discard_q;
  logic [CNT_W-1:0] inflight_nxt;
  logic [CNT_W-1:0] discard_nxt;
  logic             drop;

  // Responses of the old stream are eaten first, they come back in order
  assign drop     = rvalid_i && (discard_q != '0);
  assign accept_o = rvalid_i && (discard_q == '0) && !flush_i;

  // Count after this cycle's events, before any flush
  assign inflight_nxt = inflight_q + CNT_W'(issue_i) - CNT_W'(rvalid_i && !drop);
  assign discard_nxt  = discard_q - CNT_W'(drop);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inflight_q <= '0;
      discard_q  <= '0;
    end else if (flush_i) begin
      // Grant in the flush cycle still carries the old address
      discard_q  <= discard_nxt + inflight_nxt;
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_nxt;
      discard_q  <= discard_nxt;
    end
  end

  // Every live fetch has a reserved buffer entry
  assign slot_free_o = (inflight_q + CNT_W'(buf_count_i)) < CNT_W'(`IF_MAX_OUTSTANDING);

  assign busy_o = (inflight_q != '0) || (discard_q != '0) || (buf_count_i != '0);

endmodule

//--- fetch_buffer.sv
// Two-entry FIFO of fetched words with PC and error flag
`timescale 1ns/1ps
`include "if_cfg.svh"

module fetch_buffer import if_data_pkg::*; (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                push_i,
  input  instr_rsp_t                          rsp_i,
  input  logic [`IF_XLEN-1:0]                 push_pc_i,
  input  logic                                pop_i,
  input  logic                                flush_i,
  output fetch_entry_t                        head_o,
  output logic                                head_valid_o,
  output logic [$clog2(`IF_BUF_DEPTH+1)-1:0]  count_o
);

  localparam int unsigned PTR_W = $clog2(`IF_BUF_DEPTH);
  localparam int unsigned CNT_W = $clog2(`IF_BUF_DEPTH+1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`IF_BUF_DEPTH - 1);

  fetch_entry_t        mem_q [`IF_BUF_DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    count_q;
  logic [`IF_XLEN-1:0] rsp_pc_q;
  logic                do_push;
  logic                do_pop;

  // Redirect takes priority over both ends
  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && !flush_i && (count_q != '0);

  //////////////////////////////////////////////////
  // Pointers, fill level and response address
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      rsp_pc_q <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      // First response of the new stream belongs to the target
      rsp_pc_q <= {push_pc_i[`IF_XLEN-1:2], 2'b00};
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
        rsp_pc_q <= rsp_pc_q + `IF_XLEN'd4;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // Storage, no reset needed
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= '{pc: rsp_pc_q, instr: rsp_i.rdata, err: rsp_i.err};
    end
  end

  assign head_o       = mem_q[rd_ptr_q];
  assign head_valid_o = (count_q != '0);
  assign count_o      = count_q;

endmodule

//--- if_id_reg.sv
// IF/ID pipeline register with kill, halt, stall and compressed-parcel capture
`timescale 1ns/1ps
`include "if_cfg.svh"

module if_id_reg import if_ctrl_pkg::*, if_data_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  if_ctrl_t      ctrl_i,
  input  fetch_entry_t  head_i,
  input  logic          head_valid_i,
  input  logic          id_ready_i,
  output logic          pop_o,
  output if_id_t        if_id_o
);

  logic                load;
  logic                head_is_rvc;
  logic                valid_q;
  logic [`IF_XLEN-1:0] pc_q;
  logic [`IF_XLEN-1:0] instr_q;
  logic                err_q;
  logic                rvc_q;
  logic [15:0]         c_instr_q;

  // Move the head into ID only when IF is live and ID takes it
  assign load  = head_valid_i && !ctrl_i.kill_if && !ctrl_i.halt_if && id_ready_i;
  assign pop_o = load;

  // RVC when low parcel opcode bits are not 2'b11
  assign head_is_rvc = (head_i.instr.parcel.lo[1:0] != 2'b11);

  //////////////////////////////////////////////////
  // Valid bit
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      // ID consumed it, nothing new behind
      valid_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Payload, frozen while ID stalls
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      pc_q    <= head_i.pc;
      instr_q <= head_i.instr.word;
      err_q   <= head_i.err;
      rvc_q   <= head_is_rvc;
      // Keeps the last RVC parcel across 32-bit words
      if (head_is_rvc) begin
        c_instr_q <= head_i.instr.parcel.lo;
      end
    end
  end

  assign if_id_o = '{
    instr_valid:      valid_q,
    pc:               pc_q,
    instr:            instr_q,
    bus_err:          err_q,
    is_compressed:    rvc_q,
    compressed_instr: c_instr_q
  };

endmodule

//--- if_top.sv
// Instruction fetch stage top level connecting PC select, prefetch, buffer and IF/ID
`timescale 1ns/1ps
`include "if_cfg.svh"

module if_top import if_ctrl_pkg::*, if_data_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // Controller
  input  if_ctrl_t             ctrl_i,
  input  pc_targets_t          targets_i,
  // Instruction bus
  output instr_req_t           bus_req_o,
  input  instr_rsp_t           bus_rsp_i,
  // ID stage and status
  output if_id_t               if_id_o,
  input  logic                 id_ready_i,
  output logic [`IF_XLEN-1:0]  pc_if_o,
  output logic                 if_busy_o,
  output logic                 csr_mtvec_init_o
);

  logic [`IF_XLEN-1:0]                branch_addr;
  logic                               slot_free;
  logic                               issue;
  logic                               flush;
  logic                               accept;
  logic [$clog2(`IF_BUF_DEPTH+1)-1:0] buf_count;
  fetch_entry_t                       head;
  logic                               head_valid;
  logic                               pop;

  // Redirect target, same cycle as pc_set
  pc_select u_pc_select (
    .ctrl_i           (ctrl_i),
    .targets_i        (targets_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  //////////////////////////////////////////////////
  // Prefetch
  //////////////////////////////////////////////////

  fetch_fsm u_fetch_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .branch_addr_i (branch_addr),
    .slot_free_i   (slot_free),
    .bus_gnt_i     (bus_rsp_i.gnt),
    .bus_req_o     (bus_req_o),
    .issue_o       (issue),
    .flush_o       (flush)
  );

  // Filters stale responses after a redirect
  txn_counter u_txn_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_i     (issue),
    .rvalid_i    (bus_rsp_i.rvalid),
    .flush_i     (flush),
    .buf_count_i (buf_count),
    .slot_free_o (slot_free),
    .accept_o    (accept),
    .busy_o      (if_busy_o)
  );

  //////////////////////////////////////////////////
  // Buffer and pipeline register
  //////////////////////////////////////////////////

  fetch_buffer u_fetch_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (accept),
    .rsp_i        (bus_rsp_i),
    .push_pc_i    (branch_addr),
    .pop_i        (pop),
    .flush_i      (flush),
    .head_o       (head),
    .head_valid_o (head_valid),
    .count_o      (buf_count)
  );

  if_id_reg u_if_id_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .head_i       (head),
    .head_valid_i (head_valid),
    .id_ready_i   (id_ready_i),
    .pop_o        (pop),
    .if_id_o      (if_id_o)
  );

  // PC of the word offered to IF/ID
  assign pc_if_o = head.pc;

endmodule

//--- tb_checker.sv
// Checker that predicts IF/ID contents, fetch PC, busy, bus address hold and the mtvec-init pulse
`timescale 1ns/1ps
`include "if_cfg.svh"

module tb_checker import if_ctrl_pkg::*, if_data_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  if_ctrl_t             ctrl_i,
  input  instr_req_t           bus_req_i,
  input  instr_rsp_t           bus_rsp_i,
  input  if_id_t               if_id_i,
  input  logic                 id_ready_i,
  input  logic                 csr_mtvec_init_i,
  input  logic [`IF_XLEN-1:0]  pc_if_i,
  input  logic                 if_busy_i,
  input  logic                 exp_init_i,
  input  logic [`IF_XLEN-1:0]  exp_target_i,
  input  logic                 row_end_i,
  output int                   errors_o,
  output int                   checks_o
);

  if_id_t              prev_id;
  logic                prev_ready;
  logic                prev_halt;
  logic                prev_req;
  logic                prev_gnt;
  logic                prev_rvalid;
  logic                prev_pc_set;
  logic [`IF_XLEN-1:0] prev_addr;
  logic [`IF_XLEN-1:0] prev_pc_if;
  logic [`IF_XLEN-1:0] exp_pc;
  logic [15:0]         last_c;
  logic                have_c;
  logic                started;
  pc_mux_e             row_mux;
  int                  row_items;
  int                  row_errors;
  int                  row_num;
  int                  outstanding;

  // Memory contents, mixes every address bit
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {a[17:2] ^ 16'hC3A5, a[31:18] ^ 14'h01B7, a[3:2]};
  endfunction

  // Marked bus error window
  function automatic logic in_err_window(input logic [31:0] a);
    return (a >= 32'h0000_2000) && (a < 32'h0000_2010);
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks_o++;
    if (exp !== got) begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
      errors_o++;
      row_errors++;
    end
  endtask

  task automatic flag(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors_o++;
    row_errors++;
  endtask

  initial begin
    errors_o = 0;
    checks_o = 0;
    have_c = 1'b0;
    started = 1'b0;
    row_num = 0;
    row_items = 0;
    row_errors = 0;
    outstanding = 0;
    prev_id = '0;
    prev_ready = 1'b0;
    prev_halt = 1'b0;
    prev_req = 1'b0;
    prev_gnt = 1'b0;
    prev_rvalid = 1'b0;
    prev_pc_set = 1'b0;
    prev_addr = '0;
    prev_pc_if = '0;
  end

  ////////////////////////////////////////////////////
  // Sampled mid-cycle, all inputs settled
  ////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      compare("csr_mtvec_init_o", exp_init_i, csr_mtvec_init_i);
      // Granted minus returned fetches on the bus
      if (prev_req && prev_gnt) outstanding++;
      if (prev_rvalid) outstanding--;
      if (outstanding > 0) compare("if_busy_o", 1'b1, if_busy_i);
      // Nothing fetched before the first redirect
      if (!started) compare("if_busy_o", 1'b0, if_busy_i);
      // Waiting request keeps its address
      if (prev_req && !prev_gnt && !prev_pc_set) begin
        compare("bus_req_o.req", 1'b1, bus_req_i.req);
        compare("bus_req_o.addr", prev_addr, bus_req_i.addr);
      end
      if (prev_id.instr_valid && !prev_ready) begin
        // ID stalled, register frozen
        checks_o++;
        if (if_id_i !== prev_id) begin
          $display("CHECK FAILED at %0t: if_id_o expected %h got %h", $time, prev_id, if_id_i);
          errors_o++;
          row_errors++;
        end
      end else if (if_id_i.instr_valid) begin
        if (prev_halt) flag("IF/ID loaded a new word while halt_if was high");
        if (!started) flag("IF/ID valid before the first redirect");
        // Head PC seen one cycle before the load
        compare("pc_if_o", exp_pc, prev_pc_if);
        compare("if_id_o.pc", exp_pc, if_id_i.pc);
        compare("if_id_o.instr", mem_word(exp_pc), if_id_i.instr);
        compare("if_id_o.bus_err", in_err_window(exp_pc), if_id_i.bus_err);
        compare("if_id_o.is_compressed", mem_word(exp_pc) % 4 != 3, if_id_i.is_compressed);
        if (mem_word(exp_pc) % 4 != 3) begin
          last_c = mem_word(exp_pc) % 65536;
          have_c = 1'b1;
        end
        if (have_c) compare("if_id_o.compressed_instr", last_c, if_id_i.compressed_instr);
        exp_pc = exp_pc + 32'd4;
        row_items++;
      end
      // New stream starts at the table target
      if (ctrl_i.pc_set) begin
        exp_pc = exp_target_i;
        row_items = 0;
        row_errors = 0;
        row_mux = ctrl_i.pc_mux;
        started = 1'b1;
      end
      if (row_end_i) begin
        $display("Row %0d %s: %0d words, %0d errors", row_num, row_mux.name(),
                 row_items, row_errors);
        row_num++;
      end
      prev_id = if_id_i;
      prev_ready = id_ready_i;
      prev_halt = ctrl_i.halt_if;
      prev_req = bus_req_i.req;
      prev_gnt = bus_rsp_i.gnt;
      prev_rvalid = bus_rsp_i.rvalid;
      prev_pc_set = ctrl_i.pc_set;
      prev_addr = bus_req_i.addr;
      prev_pc_if = pc_if_i;
    end
  end

endmodule

//--- tb_if_top.sv
// Testbench top with clock, reset, bus memory model, stimulus table and watchdog
`timescale 1ns/1ps
`include "if_cfg.svh"

module tb_if_top import if_ctrl_pkg::*, if_data_pkg::*;;

  localparam int ROWS = 9;
  // Generous bound per row in ns
  localparam int ROW_BOUND_NS = 300 * 100;

  typedef struct packed {
    pc_mux_e      mux;
    logic [4:0]   irq;
    logic [31:0]  exp_pc;
    logic [7:0]   n_instr;
    logic [3:0]   ready_pat;  // id_ready duty, bit per cycle
    logic [3:0]   halt_cyc;
    logic         exp_init;   // mtvec-init pulse expected with the redirect
  } row_t;

  logic         clk;
  logic         rst_n;
  if_ctrl_t     ctrl;
  pc_targets_t  targets;
  instr_req_t   bus_req;
  instr_rsp_t   bus_rsp;
  if_id_t       if_id;
  logic         id_ready;
  logic [31:0]  pc_if;
  logic         if_busy;
  logic         mtvec_init;
  logic [31:0]  exp_target;
  logic         exp_init;
  logic         row_end;
  int           errors;
  int           checks;
  row_t         rows [ROWS];
  logic [31:0]  lcg_state = 32'd15;
  logic [31:0]  q_addr [$];
  int unsigned  q_due [$];
  int unsigned  cyc;
  int unsigned  last_due;
  int unsigned  gnt_wait;
  int unsigned  due;

  if_top u_dut (
    .clk (clk), .rst_n (rst_n), .ctrl_i (ctrl), .targets_i (targets),
    .bus_req_o (bus_req), .bus_rsp_i (bus_rsp), .if_id_o (if_id),
    .id_ready_i (id_ready), .pc_if_o (pc_if), .if_busy_o (if_busy),
    .csr_mtvec_init_o (mtvec_init)
  );

  tb_checker u_chk (
    .clk (clk), .rst_n (rst_n), .ctrl_i (ctrl), .bus_req_i (bus_req),
    .bus_rsp_i (bus_rsp), .if_id_i (if_id), .id_ready_i (id_ready),
    .csr_mtvec_init_i (mtvec_init), .pc_if_i (pc_if), .if_busy_i (if_busy),
    .exp_init_i (exp_init), .exp_target_i (exp_target),
    .row_end_i (row_end), .errors_o (errors), .checks_o (checks)
  );

  function automatic logic [14:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:16];
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {a[17:2] ^ 16'hC3A5, a[31:18] ^ 14'h01B7, a[3:2]};
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////
  // Memory model, random grant delay, in-order data
  ////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_rsp <= '0;
      cyc = 0;
      last_due = 0;
      gnt_wait = 0;
    end else begin
      cyc++;
      if (bus_req.req && bus_rsp.gnt) begin
        due = cyc + (lcg_next() % 3);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        q_addr.push_back(bus_req.addr);
        q_due.push_back(due);
        gnt_wait = lcg_next() % 3;
      end else if (bus_req.req && gnt_wait > 0) begin
        gnt_wait--;
      end
      bus_rsp.gnt <= (gnt_wait == 0);
      if (q_due.size() > 0 && q_due[0] == cyc) begin
        bus_rsp.rvalid <= 1'b1;
        bus_rsp.rdata <= mem_word(q_addr[0]);
        bus_rsp.err <= (q_addr[0] >= 32'h2000) && (q_addr[0] < 32'h2010);
        void'(q_addr.pop_front());
        void'(q_due.pop_front());
      end else begin
        bus_rsp.rvalid <= 1'b0;
        bus_rsp.err <= 1'b0;
      end
    end
  end

  task automatic load_table();
    rows[0] = '{PC_BOOT,     5'd0, 32'h0000_1000, 8'd6, 4'b1111, 4'd0, 1'b1};
    rows[1] = '{PC_JUMP,     5'd0, 32'h0000_2000, 8'd6, 4'b1011, 4'd0, 1'b0};
    rows[2] = '{PC_BRANCH,   5'd0, 32'h0000_3100, 8'd5, 4'b0101, 4'd3, 1'b0};
    rows[3] = '{PC_MRET,     5'd0, 32'h0000_4200, 8'd4, 4'b1111, 4'd0, 1'b0};
    rows[4] = '{PC_DRET,     5'd0, 32'h0000_5300, 8'd7, 4'b0011, 4'd2, 1'b0};
    rows[5] = '{PC_TRAP_EXC, 5'd0, 32'h0000_8000, 8'd4, 4'b1111, 4'd0, 1'b0};
    rows[6] = '{PC_TRAP_IRQ, 5'd5, 32'h0000_8014, 8'd5, 4'b1101, 4'd0, 1'b0};
    rows[7] = '{PC_TRAP_NMI, 5'd0, 32'h0000_803C, 8'd4, 4'b1111, 4'd0, 1'b0};
    rows[8] = '{PC_TRAP_DBD, 5'd0, 32'h0000_6400, 8'd6, 4'b0110, 4'd4, 1'b0};
  endtask

  // Redirect, then accept words until the row count is reached
  task automatic apply_row(input row_t r);
    int unsigned got;
    int unsigned cnt;
    int unsigned halt_left;
    got = 0;
    cnt = 0;
    halt_left = r.halt_cyc;
    @(posedge clk);
    row_end <= 1'b0;
    ctrl <= '{pc_set: 1'b1, pc_mux: r.mux, kill_if: 1'b1, halt_if: 1'b0, mtvec_pc_mux: r.irq};
    exp_target <= r.exp_pc;
    exp_init <= r.exp_init;
    id_ready <= 1'b1;
    @(posedge clk);
    ctrl <= '0;
    exp_init <= 1'b0;
    while (got < r.n_instr) begin
      @(posedge clk);
      if (if_id.instr_valid && id_ready) got++;
      id_ready <= r.ready_pat[cnt % 4];
      if (got > 0 && halt_left > 0) begin
        ctrl.halt_if <= 1'b1;
        halt_left--;
      end else begin
        ctrl.halt_if <= 1'b0;
      end
      cnt++;
    end
    row_end <= 1'b1;
    ctrl.halt_if <= 1'b0;
  endtask

  initial begin
    rst_n <= 1'b0;
    ctrl <= '0;
    targets <= '{boot_addr: 32'h0000_1002, jump_target: 32'h0000_2000,
                 branch_target: 32'h0000_3100, mepc: 32'h0000_4200, dpc: 32'h0000_5300,
                 dm_halt_addr: 32'h0000_6403, mtvec_addr: 25'h100};
    id_ready <= 1'b0;
    exp_target <= '0;
    exp_init <= 1'b0;
    row_end <= 1'b0;
    load_table();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < ROWS; i++) begin
      apply_row(rows[i]);
    end
    @(posedge clk);
    row_end <= 1'b0;
    repeat (4) @(posedge clk);
    $display("Rows %0d, checks %0d, errors %0d", ROWS, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog scaled to the table length
  initial begin
    #(ROWS * ROW_BOUND_NS + 1000);
    $display("Timeout: the stimulus table did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
if_ctrl_pkg.sv
if_data_pkg.sv
pc_select.sv
fetch_fsm.sv
txn_counter.sv
fetch_buffer.sv
if_id_reg.sv
if_top.sv
tb_checker.sv
tb_if_top.sv

//--- Bender.yml
package:
  name: if_stage

export_include_dirs:
  - .

sources:
  - if_ctrl_pkg.sv
  - if_data_pkg.sv
  - pc_select.sv
  - fetch_fsm.sv
  - txn_counter.sv
  - fetch_buffer.sv
  - if_id_reg.sv
  - if_top.sv
  - target: simulation
    files:
      - tb_checker.sv
      - tb_if_top.sv
